/* hdl/tcb_pkg.sv */
package tcb_pkg;

//////////////////////////////////////////////////
// bus dimensions
//////////////////////////////////////////////////

  // byte address width
  localparam int unsigned tcb_adr_w = 16;

  // bytes per data word
  localparam int unsigned tcb_bew = 4;

  // data word width
  localparam int unsigned tcb_dat_w = 32;

  // address bits selecting a byte inside a word
  localparam int unsigned tcb_off_w = $clog2(tcb_bew);

  // byte offset inside a word
  typedef logic [tcb_off_w-1:0] tcb_off_t;

//////////////////////////////////////////////////
// transfer size
//////////////////////////////////////////////////

  // log2 of the byte count
  typedef logic [1:0] tcb_siz_t;

  // legal sizes
  localparam tcb_siz_t tcb_siz_b = 2'd0;
  localparam tcb_siz_t tcb_siz_h = 2'd1;
  localparam tcb_siz_t tcb_siz_w = 2'd2;
  // value 3 is never supported

//////////////////////////////////////////////////
// reference mode request and response
//////////////////////////////////////////////////

  // payload right aligned in wdt
  typedef struct packed {
    logic                 wen;
    // 0 little endian, 1 big endian
    logic                 ndn;
    tcb_siz_t             siz;
    logic [tcb_adr_w-1:0] adr;
    logic [tcb_dat_w-1:0] wdt;
  } tcb_req_t;

  // payload right aligned, upper bytes zero
  typedef struct packed {
    logic [tcb_dat_w-1:0] rdt;
    // error status
    logic                 sts;
  } tcb_rsp_t;

//////////////////////////////////////////////////
// memory mode request
//////////////////////////////////////////////////

  // word aligned address, data in lane positions
  typedef struct packed {
    logic                 wen;
    logic [tcb_adr_w-1:0] adr;
    logic [tcb_bew-1:0]   ben;
    logic [tcb_dat_w-1:0] wdt;
  } tcb_mem_req_t;

endpackage

/* hdl/tcb_align_check.sv */
`timescale 1ns/10ps

module tcb_align_check
  import tcb_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // subordinate side facing the manager
  input  logic     up_vld,
  input  tcb_req_t up_req,
  output logic     up_rdy,
  output logic     up_rsp_vld,
  output tcb_rsp_t up_rsp,
  // misaligned or oversize request presented
  output logic     mal,
  // manager side facing the converter
  output logic     dn_vld,
  output tcb_req_t dn_req,
  input  logic     dn_rdy,
  input  logic     dn_rsp_vld,
  input  tcb_rsp_t dn_rsp
);

  // error response content
  localparam tcb_rsp_t err_rsp = '{rdt: '0, sts: 1'b1};

  // upstream transfer
  logic up_trn;

  // pending error response
  logic err_vld;

//////////////////////////////////////////////////
// alignment decode
//////////////////////////////////////////////////

  // same decode for reads and writes
  always_comb begin
    case (up_req.siz)
      // single bytes are always aligned
      tcb_siz_b: mal = 1'b0;
      // half word needs even address
      tcb_siz_h: mal = up_req.adr[0];
      // word needs both low bits clear
      tcb_siz_w: mal = |up_req.adr[1:0];
      // size 3 is unsupported
      default:   mal = 1'b1;
    endcase
  end

//////////////////////////////////////////////////
// request forwarding
//////////////////////////////////////////////////

  // bad requests use the same ready as good ones
  assign up_rdy = dn_rdy;
  assign up_trn = up_vld & up_rdy;

  // only aligned requests go downstream
  assign dn_vld = up_vld & ~mal;
  assign dn_req = up_req;

//////////////////////////////////////////////////
// error response
//////////////////////////////////////////////////

  // one cycle after a rejected transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_vld <= 1'b0;
    end else begin
      err_vld <= up_trn & mal;
    end
  end

//////////////////////////////////////////////////
// response merge
//////////////////////////////////////////////////

  // single request stream
  // so error and memory responses never overlap
  assign up_rsp_vld = dn_rsp_vld | err_vld;

  always_comb begin
    if (err_vld) begin
      up_rsp = err_rsp;
    end else begin
      up_rsp = dn_rsp;
    end
  end

endmodule

/* hdl/tcb_lib_converter.sv */
`timescale 1ns/10ps

module tcb_lib_converter
  import tcb_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  // reference mode subordinate port
  input  logic               sub_vld,
  input  tcb_req_t           sub_req,
  output logic               sub_rdy,
  output logic               sub_rsp_vld,
  output tcb_rsp_t           sub_rsp,
  // memory mode manager port
  output logic               man_vld,
  output tcb_mem_req_t       man_req,
  input  logic               man_rdy,
  input  logic               man_rsp_vld,
  input  logic [tcb_dat_w-1:0] man_rdt
);

  // data words as byte arrays
  logic [tcb_bew-1:0][7:0] sub_wdt;
  logic [tcb_bew-1:0][7:0] man_wdt;
  logic [tcb_bew-1:0][7:0] man_rdb;
  logic [tcb_bew-1:0][7:0] sub_rdt;

  // per lane write select and activity
  tcb_off_t           req_sel [tcb_bew];
  logic [tcb_bew-1:0] req_act;

  // per payload byte read select and activity
  tcb_off_t           rsp_sel [tcb_bew];
  logic [tcb_bew-1:0] rsp_act;

  // attributes kept for the response
  tcb_off_t rsp_off;
  tcb_siz_t rsp_siz;
  logic     rsp_ndn;

//////////////////////////////////////////////////
// request handshake and address
//////////////////////////////////////////////////

  // memory decides acceptance
  assign man_vld = sub_vld;
  assign sub_rdy = man_rdy;

  assign man_req.wen = sub_req.wen;
  // drop offset bits for a word address
  assign man_req.adr = {sub_req.adr[tcb_adr_w-1:tcb_off_w], {tcb_off_w{1'b0}}};

//////////////////////////////////////////////////
// write lane steering
//////////////////////////////////////////////////

  // lane i carries payload byte sel
  always_comb begin
    int off;
    int cnt;
    off = int'(sub_req.adr[tcb_off_w-1:0]);
    cnt = 1 << sub_req.siz;
    for (int i = 0; i < tcb_bew; i++) begin
      // n lanes starting at the offset
      req_act[i] = (i >= off) && (i < off + cnt);
      if (sub_req.ndn) begin
        // big endian reverses bytes inside the span
        req_sel[i] = tcb_off_t'(off + cnt - 1 - i);
      end else begin
        req_sel[i] = tcb_off_t'(i - off);
      end
    end
  end

  assign sub_wdt = sub_req.wdt;

  // idle lanes carry zero
  always_comb begin
    for (int i = 0; i < tcb_bew; i++) begin
      man_wdt[i] = req_act[i] ? sub_wdt[req_sel[i]] : 8'h00;
    end
  end

  assign man_req.ben = req_act;
  assign man_req.wdt = man_wdt;

//////////////////////////////////////////////////
// attributes for the response path
//////////////////////////////////////////////////

  // captured at each transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_off <= '0;
      rsp_siz <= tcb_siz_b;
      rsp_ndn <= 1'b0;
    end else if (sub_vld & sub_rdy) begin
      rsp_off <= sub_req.adr[tcb_off_w-1:0];
      rsp_siz <= sub_req.siz;
      rsp_ndn <= sub_req.ndn;
    end
  end

//////////////////////////////////////////////////
// read lane steering
//////////////////////////////////////////////////

  // payload byte k comes from lane sel
  always_comb begin
    int off;
    int cnt;
    off = int'(rsp_off);
    cnt = 1 << rsp_siz;
    for (int k = 0; k < tcb_bew; k++) begin
      // bytes above the size read as zero
      rsp_act[k] = k < cnt;
      if (rsp_ndn) begin
        rsp_sel[k] = tcb_off_t'(off + cnt - 1 - k);
      end else begin
        rsp_sel[k] = tcb_off_t'(off + k);
      end
    end
  end

  assign man_rdb = man_rdt;

  always_comb begin
    for (int k = 0; k < tcb_bew; k++) begin
      sub_rdt[k] = rsp_act[k] ? man_rdb[rsp_sel[k]] : 8'h00;
    end
  end

  // memory never reports an error
  assign sub_rsp_vld = man_rsp_vld;
  assign sub_rsp.rdt = sub_rdt;
  assign sub_rsp.sts = 1'b0;

endmodule

/* hdl/tcb_mem.sv */
`timescale 1ns/10ps

module tcb_mem
  import tcb_pkg::*;
#(
  // depth in words, power of two
  parameter int unsigned mem_words = 256
)(
  input  logic                 clk,
  input  logic                 rst_n,
  // memory mode request
  input  logic                 vld,
  input  tcb_mem_req_t         req,
  output logic                 rdy,
  // registered response
  output logic                 rsp_vld,
  output logic [tcb_dat_w-1:0] rdt
);

  // word index width
  localparam int unsigned idx_w = $clog2(mem_words);

  // storage with byte lanes
  logic [tcb_bew-1:0][7:0] mem [mem_words];

  // word index from byte address
  logic [idx_w-1:0] idx;

  // request accepted
  logic trn;

//////////////////////////////////////////////////
// address and handshake
//////////////////////////////////////////////////

  // upper address bits wrap above the depth
  assign idx = req.adr[idx_w+tcb_off_w-1:tcb_off_w];
  assign trn = vld & rdy;

  // ready from the first cycle after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy     <= 1'b0;
      rsp_vld <= 1'b0;
    end else begin
      rdy     <= 1'b1;
      rsp_vld <= trn;
    end
  end

//////////////////////////////////////////////////
// array access
//////////////////////////////////////////////////

  // write per lane under its enable
  always_ff @(posedge clk) begin
    if (trn & req.wen) begin
      for (int i = 0; i < tcb_bew; i++) begin
        if (req.ben[i]) begin
          mem[idx][i] <= req.wdt[8*i+:8];
        end
      end
    end
  end

  // whole word read on every transfer
  // old content is returned on a write
  always_ff @(posedge clk) begin
    if (trn) begin
      rdt <= mem[idx];
    end
  end

endmodule

/* hdl/tcb_bridge_top.sv */
`timescale 1ns/10ps

module tcb_bridge_top
  import tcb_pkg::*;
#(
  // RAM depth in words
  parameter int unsigned mem_words = 256
)(
  input  logic     clk,
  input  logic     rst_n,
  // manager request
  input  logic     req_vld,
  input  tcb_req_t req,
  output logic     req_rdy,
  // response one cycle after transfer
  output logic     rsp_vld,
  output tcb_rsp_t rsp,
  // misaligned request presented
  output logic     mal
);

  // check to converter
  logic     cnv_vld;
  tcb_req_t cnv_req;
  logic     cnv_rdy;
  logic     cnv_rsp_vld;
  tcb_rsp_t cnv_rsp;

  // converter to memory
  logic                 mem_vld;
  tcb_mem_req_t         mem_req;
  logic                 mem_rdy;
  logic                 mem_rsp_vld;
  logic [tcb_dat_w-1:0] mem_rdt;

//////////////////////////////////////////////////
// input side
//////////////////////////////////////////////////

  tcb_align_check align_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .up_vld     (req_vld),
    .up_req     (req),
    .up_rdy     (req_rdy),
    .up_rsp_vld (rsp_vld),
    .up_rsp     (rsp),
    .mal        (mal),
    .dn_vld     (cnv_vld),
    .dn_req     (cnv_req),
    .dn_rdy     (cnv_rdy),
    .dn_rsp_vld (cnv_rsp_vld),
    .dn_rsp     (cnv_rsp)
  );

//////////////////////////////////////////////////
// mode converter
//////////////////////////////////////////////////

  tcb_lib_converter conv_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sub_vld     (cnv_vld),
    .sub_req     (cnv_req),
    .sub_rdy     (cnv_rdy),
    .sub_rsp_vld (cnv_rsp_vld),
    .sub_rsp     (cnv_rsp),
    .man_vld     (mem_vld),
    .man_req     (mem_req),
    .man_rdy     (mem_rdy),
    .man_rsp_vld (mem_rsp_vld),
    .man_rdt     (mem_rdt)
  );

//////////////////////////////////////////////////
// output side
//////////////////////////////////////////////////

  tcb_mem #(
    .mem_words (mem_words)
  ) mem_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (mem_vld),
    .req     (mem_req),
    .rdy     (mem_rdy),
    .rsp_vld (mem_rsp_vld),
    .rdt     (mem_rdt)
  );

endmodule

/* bench/tcb_bridge_properties.sv */
`timescale 1ns/10ps

module tcb_bridge_properties
  import tcb_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     req_vld,
  input tcb_req_t req,
  input logic     req_rdy,
  input logic     rsp_vld
);

  // request transfers on this edge
  logic trn;

  assign trn = req_vld & req_rdy;

//////////////////////////////////////////////////
// response timing
//////////////////////////////////////////////////

  // every transfer answered on the next edge
  rsp_after_trn: assert property (
    @(posedge clk) disable iff (!rst_n) trn |=> rsp_vld
  ) else $error("rsp_vld missing one cycle after a transfer");

  // no response without a transfer before it
  rsp_only_after_trn: assert property (
    @(posedge clk) disable iff (!rst_n) rsp_vld |-> $past(trn)
  ) else $error("rsp_vld without a transfer one cycle earlier");

//////////////////////////////////////////////////
// reset and request stability
//////////////////////////////////////////////////

  // one edge in reset clears both
  quiet_in_reset: assert property (
    @(posedge clk) !rst_n |=> (!req_rdy && !rsp_vld)
  ) else $error("req_rdy or rsp_vld high during reset");

  // a waiting request is neither withdrawn nor changed
  req_held: assert property (
    @(posedge clk) disable iff (!rst_n) (req_vld && !req_rdy) |=> (req_vld && $stable(req))
  ) else $error("request changed while waiting for req_rdy");

endmodule

bind tcb_bridge_top tcb_bridge_properties props_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_vld (req_vld),
  .req     (req),
  .req_rdy (req_rdy),
  .rsp_vld (rsp_vld)
);

/* bench/tcb_bridge_tb.sv */
`timescale 1ns/10ps

module tcb_bridge_tb
  import tcb_pkg::*;
;

  // model depth in bytes for 256 RAM words
  localparam int mem_bytes = 1024;
  // cycles allowed for any single wait
  localparam int wait_lim = 16;

  // expected response of one request
  typedef struct packed {
    logic                 bad;
    logic                 chk_rdt;
    logic [tcb_adr_w-1:0] adr;
    logic [tcb_dat_w-1:0] rdt;
  } exp_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     req_vld;
  tcb_req_t req;
  logic     req_rdy;
  logic     rsp_vld;
  tcb_rsp_t rsp;
  logic     mal;

  // byte copy of the RAM
  logic [7:0]  ref_mem [mem_bytes];
  logic [31:0] rnd_state = 32'h46d3_8bc1;
  tcb_req_t    stream_q [$];
  int          mis_cnt = 0;
  int          tmo_cnt = 0;
  // set after a timeout so later accesses are skipped
  logic        hung = 1'b0;

  always #50 clk = ~clk;

  tcb_bridge_top tcb_bridge_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .mal     (mal)
  );

//////////////////////////////////////////////////
// stimulus helpers and reference model
//////////////////////////////////////////////////

  // lcg step
  function automatic logic [31:0] next_rand();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  function automatic tcb_req_t make_req(input logic wen, input logic ndn, input tcb_siz_t siz,
                                        input logic [tcb_adr_w-1:0] adr,
                                        input logic [tcb_dat_w-1:0] wdt);
    return '{wen: wen, ndn: ndn, siz: siz, adr: adr, wdt: wdt};
  endfunction

  // offset must be a multiple of the byte count
  function automatic logic bad_req(input tcb_req_t r);
    int n;
    n = 1 << r.siz;
    if (r.siz == 2'd3) begin
      return 1'b1;
    end
    return (int'(r.adr[1:0]) % n) != 0;
  endfunction

  // model byte address of payload byte k
  function automatic int byte_adr(input tcb_req_t r, input int k);
    int off;
    int n;
    int lane;
    off = int'(r.adr[1:0]);
    n = 1 << r.siz;
    if (r.ndn) begin
      lane = off + n - 1 - k;
    end else begin
      lane = off + k;
    end
    return ((int'(r.adr) & ~3) + lane) % mem_bytes;
  endfunction

  // predicts the response and applies good writes
  function automatic exp_t model_access(input tcb_req_t r);
    exp_t e;
    int   n;
    e.bad = bad_req(r);
    e.chk_rdt = e.bad | ~r.wen;
    e.adr = r.adr;
    e.rdt = '0;
    n = 1 << r.siz;
    if (!e.bad) begin
      for (int k = 0; k < n; k++) begin
        if (r.wen) begin
          ref_mem[byte_adr(r, k)] = r.wdt[8*k +: 8];
        end else begin
          e.rdt[8*k +: 8] = ref_mem[byte_adr(r, k)];
        end
      end
    end
    return e;
  endfunction

//////////////////////////////////////////////////
// checks
//////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
    assert (got === want) else begin
      mis_cnt++;
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // read data carries a payload only for reads and rejected requests
  task automatic check_rsp(input exp_t e, input tcb_rsp_t r);
    assert (r.sts === e.bad) else begin
      mis_cnt++;
      $display("FAIL %0t ns: adr %h sts %0b, expected %0b", $time, e.adr, r.sts, e.bad);
    end
    if (e.chk_rdt) begin
      assert (r.rdt === e.rdt) else begin
        mis_cnt++;
        $display("FAIL %0t ns: adr %h rdt %h, expected %h", $time, e.adr, r.rdt, e.rdt);
      end
    end
  endtask

  // mal still shows the presented request on the transfer edge
  task automatic accept_req(input tcb_req_t r, output exp_t e);
    e = model_access(r);
    assert (mal === e.bad) else begin
      mis_cnt++;
      $display("FAIL %0t ns: mal %0b for adr %h size %0d", $time, mal, r.adr, r.siz);
    end
  endtask

  task automatic report_timeout(input string what);
    tmo_cnt++;
    hung = 1'b1;
    $display("timeout at %0t ns: %s did not arrive within %0d cycles", $time, what, wait_lim);
  endtask

//////////////////////////////////////////////////
// bus access
//////////////////////////////////////////////////

  // one request and idle until its response
  task automatic do_access(input tcb_req_t r, output tcb_rsp_t got);
    exp_t e;
    int   cnt;
    got = '0;
    if (!hung) begin
      req_vld <= 1'b1;
      req     <= r;
      cnt = 0;
      @(posedge clk);
      while (!req_rdy && cnt < wait_lim) begin
        @(posedge clk);
        cnt++;
      end
      if (!req_rdy) begin
        report_timeout("req_rdy");
      end else begin
        accept_req(r, e);
        req_vld <= 1'b0;
        cnt = 0;
        @(posedge clk);
        while (!rsp_vld && cnt < wait_lim) begin
          @(posedge clk);
          cnt++;
        end
        if (!rsp_vld) begin
          report_timeout("rsp_vld");
        end else begin
          // response exactly one cycle after transfer
          check_value(32'(cnt), 32'd0, "extra response latency");
          check_rsp(e, rsp);
          got = rsp;
        end
      end
    end
  endtask

  // req_vld held high over all of stream_q
  task automatic run_stream();
    exp_t exp_q [$];
    exp_t e;
    int   total;
    int   sent;
    int   got;
    int   cycles;
    total = stream_q.size();
    sent = 0;
    got = 0;
    cycles = 0;
    if (!hung && total > 0) begin
      req_vld <= 1'b1;
      req     <= stream_q[0];
      while (got < total && cycles < total + wait_lim) begin
        @(posedge clk);
        cycles++;
        // response of the previous transfer comes first
        if (rsp_vld) begin
          assert (exp_q.size() != 0) else begin
            mis_cnt++;
            $display("FAIL %0t ns: response with no request in flight", $time);
          end
          if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_rsp(e, rsp);
          end
          got++;
        end
        if (sent < total && req_rdy) begin
          accept_req(stream_q[sent], e);
          exp_q.push_back(e);
          sent++;
          if (sent < total) begin
            req <= stream_q[sent];
          end else begin
            req_vld <= 1'b0;
          end
        end
      end
      if (got < total) begin
        report_timeout("stream response");
      end else begin
        check_value(32'(cycles), 32'(total + 1), "stream length in cycles");
      end
    end
  endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

  task automatic check_reset();
    tcb_rsp_t r;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      // registers hold reset values after the first edge
      if (i > 0) begin
        check_value({30'd0, req_rdy, rsp_vld}, 32'd0, "req_rdy and rsp_vld in reset");
      end
    end
    rst_n <= 1'b1;
    // first request waits while req_rdy is still low
    do_access(make_req(1'b1, 1'b0, tcb_siz_w, 16'h0000, next_rand()), r);
  endtask

  // fills words 0 to 63 where all later tests stay
  task automatic test_word_access();
    tcb_rsp_t r;
    for (int i = 0; i < 64; i++) begin
      do_access(make_req(1'b1, i[0], tcb_siz_w, 16'(i * 4), next_rand()), r);
    end
    for (int i = 0; i < 64; i++) begin
      do_access(make_req(1'b0, i[0], tcb_siz_w, 16'(i * 4), 32'h0), r);
    end
  endtask

  task automatic test_sub_word();
    tcb_rsp_t r;
    // bytes at each offset leave idle lanes untouched
    for (int o = 0; o < 4; o++) begin
      do_access(make_req(1'b1, o[0], tcb_siz_b, 16'h0040 + 16'(o), next_rand()), r);
      do_access(make_req(1'b0, 1'b0, tcb_siz_w, 16'h0040, 32'h0), r);
    end
    // half words in both byte orders
    for (int o = 0; o < 4; o += 2) begin
      for (int b = 0; b < 2; b++) begin
        do_access(make_req(1'b1, b[0], tcb_siz_h, 16'h0044 + 16'(o), next_rand()), r);
        do_access(make_req(1'b0, 1'b0, tcb_siz_w, 16'h0044, 32'h0), r);
      end
    end
    // sub word reads come back low aligned
    for (int o = 0; o < 4; o++) begin
      for (int b = 0; b < 2; b++) begin
        do_access(make_req(1'b0, b[0], tcb_siz_b, 16'h0044 + 16'(o), 32'h0), r);
        if (o % 2 == 0) begin
          do_access(make_req(1'b0, b[0], tcb_siz_h, 16'h0044 + 16'(o), 32'h0), r);
        end
      end
    end
  endtask

  task automatic test_endianness();
    tcb_rsp_t    r;
    logic [31:0] word;
    word = 32'h1122_3344;
    do_access(make_req(1'b1, 1'b0, tcb_siz_w, 16'h0080, word), r);
    // least significant byte sits at offset 0
    for (int o = 0; o < 4; o++) begin
      do_access(make_req(1'b0, 1'b0, tcb_siz_b, 16'h0080 + 16'(o), 32'h0), r);
      check_value(r.rdt, {24'h0, word[8*o +: 8]}, "little endian byte");
    end
    do_access(make_req(1'b0, 1'b1, tcb_siz_h, 16'h0080, 32'h0), r);
    check_value(r.rdt, 32'h0000_4433, "big endian low half");
    do_access(make_req(1'b0, 1'b1, tcb_siz_h, 16'h0082, 32'h0), r);
    check_value(r.rdt, 32'h0000_2211, "big endian high half");
  endtask

  task automatic test_misalign();
    tcb_rsp_t r;
    do_access(make_req(1'b1, 1'b0, tcb_siz_w, 16'h00c0, 32'hcafe_f00d), r);
    for (int o = 1; o < 4; o += 2) begin
      do_access(make_req(1'b1, 1'b0, tcb_siz_h, 16'h00c0 + 16'(o), next_rand()), r);
      do_access(make_req(1'b0, 1'b1, tcb_siz_h, 16'h00c0 + 16'(o), 32'h0), r);
    end
    for (int o = 1; o < 4; o++) begin
      do_access(make_req(1'b1, o[0], tcb_siz_w, 16'h00c0 + 16'(o), next_rand()), r);
    end
    // size 3 fails at any address
    do_access(make_req(1'b1, 1'b0, 2'd3, 16'h00c0, next_rand()), r);
    do_access(make_req(1'b0, 1'b0, 2'd3, 16'h00c0, 32'h0), r);
    do_access(make_req(1'b0, 1'b0, tcb_siz_w, 16'h00c0, 32'h0), r);
    check_value(r.rdt, 32'hcafe_f00d, "word after rejected writes");
  endtask

  // random mix with bad requests included
  task automatic test_back_to_back();
    logic [31:0] rnd;
    stream_q.delete();
    for (int i = 0; i < 32; i++) begin
      rnd = next_rand();
      stream_q.push_back(make_req(rnd[31], rnd[30], rnd[29:28], {8'h00, rnd[27:20]},
                                  next_rand()));
    end
    run_stream();
  endtask

//////////////////////////////////////////////////
// main sequence
//////////////////////////////////////////////////

  initial begin
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req     = '0;
    check_reset();
    test_word_access();
    test_sub_word();
    test_endianness();
    test_misalign();
    test_back_to_back();
    $display("errors: %0d mismatches, %0d timeouts", mis_cnt, tmo_cnt);
    if (mis_cnt == 0 && tmo_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/tcb_pkg.sv
hdl/tcb_align_check.sv
hdl/tcb_lib_converter.sv
hdl/tcb_mem.sv
hdl/tcb_bridge_top.sv
bench/tcb_bridge_properties.sv
bench/tcb_bridge_tb.sv

/* Makefile */
# Verilator build and run of the TCB bridge testbench

OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tcb_bridge_tb \
	  -f compile.f --Mdir $(OBJ) -o tcb_bridge_sim
	./$(OBJ)/tcb_bridge_sim | tee sim.log
	@if grep -q "Some tests failed" sim.log; then \
	  echo "test: testbench reported errors"; exit 1; fi
	@if ! grep -q "All tests passed" sim.log; then \
	  echo "test: simulation ended before the final report"; exit 1; fi

clean:
	rm -rf $(OBJ) sim.log
